/* Bender.yml */
package:
  name: spi_reg

sources:
  # design, package first
  - hw/spi_reg_pkg.sv
  - hw/reg_bus_if.sv
  - hw/spi_frame_rx.sv
  - hw/fix_reg_list.sv
  - hw/ctrl_reg_list.sv
  - hw/spi_miso_tx.sv
  - hw/spi_reg_top.sv
  # testbench
  - target: simulation
    files:
      - verif/spi_reg_properties.sv
      - verif/tb_spi_reg.sv

/* build.f */
hw/spi_reg_pkg.sv
hw/reg_bus_if.sv
hw/spi_frame_rx.sv
hw/fix_reg_list.sv
hw/ctrl_reg_list.sv
hw/spi_miso_tx.sv
hw/spi_reg_top.sv
verif/spi_reg_properties.sv
verif/tb_spi_reg.sv

/* hw/ctrl_reg_list.sv */
// writes land on the edge ending wr_en; led_ctrl keeps only LED_WIDTH bits, frame count wraps
`timescale 1ns/1ps
`default_nettype none

module ctrl_reg_list
	import spi_reg_pkg::*;
#(
	parameter int LED_WIDTH = 4
) (
	input  logic                 clk_sample,
	input  logic                 reset,
	reg_bus_if.slave             bus,
	input  logic                 frame_done,
	output logic                 ctrl_sel,
	output reg_data_t            ctrl_rd_data,
	output logic [LED_WIDTH-1:0] led
);

	logic [DECODE_BITS-1:0] dec_addr;
	reg_data_t              scratch_q;
	logic [LED_WIDTH-1:0]   led_q;
	reg_data_t              frame_count_q;

	assign dec_addr = bus.addr[DECODE_BITS-1:0];
	assign led      = led_q;

	// --------------------------------------------------------------------------
	// write side
	// --------------------------------------------------------------------------
	always_ff @(posedge clk_sample) begin
		if (reset) begin
			scratch_q <= '0;
			led_q     <= '0;
		end else if (bus.wr_en) begin
			case (dec_addr)
				ADDR_SCRATCH[DECODE_BITS-1:0]:  scratch_q <= bus.wr_data;
				ADDR_LED_CTRL[DECODE_BITS-1:0]: led_q <= bus.wr_data[LED_WIDTH-1:0];
				// frame count and unmapped writes dropped
				default: ;
			endcase
		end
	end

	// completed frames, any valid opcode
	always_ff @(posedge clk_sample) begin
		if (reset) begin
			frame_count_q <= '0;
		end else if (frame_done) begin
			frame_count_q <= frame_count_q + 16'd1;
		end
	end

	// --------------------------------------------------------------------------
	// read side
	// --------------------------------------------------------------------------
	always_comb begin
		ctrl_sel     = 1'b0;
		ctrl_rd_data = '0;
		if (bus.rd_en) begin
			ctrl_sel = 1'b1;
			case (dec_addr)
				ADDR_SCRATCH[DECODE_BITS-1:0]:     ctrl_rd_data = scratch_q;
				// upper led bits read 0
				ADDR_LED_CTRL[DECODE_BITS-1:0]:    ctrl_rd_data = reg_data_t'(led_q);
				ADDR_FRAME_COUNT[DECODE_BITS-1:0]: ctrl_rd_data = frame_count_q;
				default:                           ctrl_sel = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/fix_reg_list.sv */
// read-only version list; combinational decode of the low DECODE_BITS address bits, upper bits alias
`timescale 1ns/1ps
`default_nettype none

module fix_reg_list
	import spi_reg_pkg::*;
(
	reg_bus_if.slave  bus,
	output logic      fix_sel,
	output reg_data_t fix_rd_data
);

	logic [DECODE_BITS-1:0] dec_addr;

	// only the low bits decode
	assign dec_addr = bus.addr[DECODE_BITS-1:0];

	// --------------------------------------------------------------------------
	// version identifier lookup
	// --------------------------------------------------------------------------
	always_comb begin
		fix_sel     = 1'b0;
		fix_rd_data = '0;
		// select only during the read strobe
		if (bus.rd_en) begin
			fix_sel = 1'b1;
			case (dec_addr)
				ADDR_VENDOR_ID[DECODE_BITS-1:0]:      fix_rd_data = VENDOR_ID;
				ADDR_PRODUCT_ID[DECODE_BITS-1:0]:     fix_rd_data = PRODUCT_ID;
				ADDR_FPGA_VERSION_H[DECODE_BITS-1:0]: fix_rd_data = FPGA_VERSION_H;
				ADDR_FPGA_VERSION_L[DECODE_BITS-1:0]: fix_rd_data = FPGA_VERSION_L;
				ADDR_TEST_VERSION[DECODE_BITS-1:0]:   fix_rd_data = TEST_VERSION;
				// not ours
				default:                              fix_sel = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/reg_bus_if.sv */
// single clk_sample domain; rd_en and wr_en are one-cycle strobes, addr held until frame end
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if
	import spi_reg_pkg::*;
();

	// access strobes
	logic      rd_en;
	logic      wr_en;
	// target and payload
	spi_addr_t addr;
	reg_data_t wr_data;

	// frame receiver side
	modport master (
		output rd_en,
		output wr_en,
		output addr,
		output wr_data
	);

	// register list side
	modport slave (
		input rd_en,
		input wr_en,
		input addr,
		input wr_data
	);

endinterface

`default_nettype wire

/* hw/spi_frame_rx.sv */
// sclk half period must be at least SYNC_STAGES+3 clk_sample cycles; mode 0, msb first
`timescale 1ns/1ps
`default_nettype none

module spi_frame_rx
	import spi_reg_pkg::*;
#(
	parameter int SYNC_STAGES = 2
) (
	input  logic      clk_sample,
	input  logic      reset,
	input  logic      sclk,
	input  logic      cs_n,
	input  logic      mosi,
	reg_bus_if.master bus,
	output logic      sclk_fall,
	output logic      cs_active,
	output logic      frame_done
);

	// zero based index of the last bit in each field
	localparam logic [5:0] LAST_OPCODE_BIT = 6'd7;
	localparam logic [5:0] LAST_ADDR_BIT   = 6'd23;
	localparam logic [5:0] LAST_DATA_BIT   = 6'd39;

	// {sclk, cs_n, mosi} per stage
	logic [SYNC_STAGES-1:0][2:0] sync_q;
	logic        sclk_s;
	logic        cs_n_s;
	logic        mosi_s;
	logic        sclk_q;
	logic        sclk_rise;
	logic [5:0]  bit_cnt;
	reg_data_t   shift_q;
	reg_data_t   next_word;
	spi_opcode_t opcode_q;
	rx_state_t   state;

	// --------------------------------------------------------------------------
	// pin synchronizer and edge detect
	// --------------------------------------------------------------------------
	always_ff @(posedge clk_sample) begin
		if (reset) begin
			// idle pins, chip select high
			sync_q <= {SYNC_STAGES{3'b010}};
			sclk_q <= 1'b0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], {sclk, cs_n, mosi}};
			sclk_q <= sclk_s;
		end
	end

	assign {sclk_s, cs_n_s, mosi_s} = sync_q[SYNC_STAGES-1];
	assign cs_active = ~cs_n_s;
	// edges only count inside a frame
	assign sclk_rise = sclk_s & ~sclk_q & cs_active;
	assign sclk_fall = ~sclk_s & sclk_q & cs_active;
	// word including the bit arriving now
	assign next_word = {shift_q[14:0], mosi_s};

	// --------------------------------------------------------------------------
	// frame state machine
	// --------------------------------------------------------------------------
	always_ff @(posedge clk_sample) begin
		if (reset) begin
			state      <= st_opcode;
			bit_cnt    <= '0;
			opcode_q   <= '0;
			bus.rd_en  <= 1'b0;
			bus.wr_en  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			// strobes last one cycle
			bus.rd_en  <= 1'b0;
			bus.wr_en  <= 1'b0;
			frame_done <= 1'b0;
			if (!cs_active) begin
				// cs high ends or aborts the frame
				state   <= st_opcode;
				bit_cnt <= '0;
			end else if (sclk_rise && state != st_ignore) begin
				bit_cnt <= bit_cnt + 6'd1;
				case (state)
					st_opcode: begin
						if (bit_cnt == LAST_OPCODE_BIT) begin
							if (next_word[7:0] == OP_READ || next_word[7:0] == OP_WRITE) begin
								opcode_q <= next_word[7:0];
								state    <= st_addr;
							end else begin
								// unknown opcode
								state <= st_ignore;
							end
						end
					end
					st_addr: begin
						if (bit_cnt == LAST_ADDR_BIT) begin
							state     <= st_data;
							// read fires early so miso has the word for the data field
							bus.rd_en <= (opcode_q == OP_READ);
						end
					end
					st_data: begin
						if (bit_cnt == LAST_DATA_BIT) begin
							// extra bits dropped until cs rises
							state      <= st_ignore;
							bus.wr_en  <= (opcode_q == OP_WRITE);
							frame_done <= 1'b1;
						end
					end
					default: state <= st_ignore;
				endcase
			end
		end
	end

	// --------------------------------------------------------------------------
	// payload capture
	// --------------------------------------------------------------------------
	always_ff @(posedge clk_sample) begin
		if (sclk_rise) begin
			shift_q <= next_word;
		end
		// address held to frame end
		if (sclk_rise && state == st_addr && bit_cnt == LAST_ADDR_BIT) begin
			bus.addr <= next_word;
		end
		if (sclk_rise && state == st_data && bit_cnt == LAST_DATA_BIT) begin
			bus.wr_data <= next_word;
		end
	end

endmodule

`default_nettype wire

/* hw/spi_miso_tx.sv */
// miso changes only on detected sclk falling edges; it stays 0 except while the read word shifts
`timescale 1ns/1ps
`default_nettype none

module spi_miso_tx
	import spi_reg_pkg::*;
(
	input  logic      clk_sample,
	input  logic      reset,
	input  logic      rd_en,
	input  logic      fix_sel,
	input  reg_data_t fix_rd_data,
	input  logic      ctrl_sel,
	input  reg_data_t ctrl_rd_data,
	input  logic      sclk_fall,
	input  logic      cs_active,
	output logic      miso
);

	reg_data_t rd_word;
	reg_data_t shift_q;
	logic      miso_q;

	// --------------------------------------------------------------------------
	// answer merge
	// --------------------------------------------------------------------------
	always_comb begin
		// nobody selected reads as 0
		rd_word = '0;
		if (fix_sel) begin
			rd_word = fix_rd_data;
		end else if (ctrl_sel) begin
			rd_word = ctrl_rd_data;
		end
	end

	// --------------------------------------------------------------------------
	// shifter
	// --------------------------------------------------------------------------
	always_ff @(posedge clk_sample) begin
		if (reset) begin
			shift_q <= '0;
			miso_q  <= 1'b0;
		end else if (!cs_active) begin
			// frame over
			shift_q <= '0;
			miso_q  <= 1'b0;
		end else if (rd_en) begin
			shift_q <= rd_word;
		end else if (sclk_fall) begin
			// msb out first and zeros fill behind so miso drops after bit 40
			miso_q  <= shift_q[15];
			shift_q <= {shift_q[14:0], 1'b0};
		end
	end

	assign miso = miso_q;

endmodule

`default_nettype wire

/* hw/spi_reg_pkg.sv */
// spi mode 0 only, 40-bit frames of opcode, address and data; only the low 9 address bits decode
`default_nettype none

package spi_reg_pkg;

	// --------------------------------------------------------------------------
	// field widths
	// --------------------------------------------------------------------------
	typedef logic [15:0] spi_addr_t;
	// short register word
	typedef logic [15:0] reg_data_t;
	typedef logic [7:0]  spi_opcode_t;

	// low address bits seen by both lists
	localparam int DECODE_BITS = 9;

	// frame opcodes
	// anything else drops the frame
	localparam spi_opcode_t OP_WRITE = 8'h01;
	localparam spi_opcode_t OP_READ  = 8'h02;

	// --------------------------------------------------------------------------
	// fixed list
	// --------------------------------------------------------------------------
	localparam spi_addr_t ADDR_VENDOR_ID      = 16'h0000;
	localparam spi_addr_t ADDR_PRODUCT_ID     = 16'h0001;
	localparam spi_addr_t ADDR_FPGA_VERSION_H = 16'h0002;
	localparam spi_addr_t ADDR_FPGA_VERSION_L = 16'h0003;
	localparam spi_addr_t ADDR_TEST_VERSION   = 16'h0004;

	// version identifiers
	localparam reg_data_t VENDOR_ID      = 16'h4448;
	localparam reg_data_t PRODUCT_ID     = 16'h0000;
	localparam reg_data_t FPGA_VERSION_H = 16'h0102;
	localparam reg_data_t FPGA_VERSION_L = 16'h0123;
	localparam reg_data_t TEST_VERSION   = 16'h1001;

	// --------------------------------------------------------------------------
	// control list
	// --------------------------------------------------------------------------
	localparam spi_addr_t ADDR_SCRATCH     = 16'h0010;
	localparam spi_addr_t ADDR_LED_CTRL    = 16'h0011;
	localparam spi_addr_t ADDR_FRAME_COUNT = 16'h0012;

	// receiver phases
	typedef enum logic [1:0] {
		st_opcode,
		st_addr,
		st_data,
		st_ignore
	} rx_state_t;

endpackage

`default_nettype wire

/* hw/spi_reg_top.sv */
// all logic runs on clk_sample; sclk half period must be at least SYNC_STAGES+3 clk_sample cycles
`timescale 1ns/1ps
`default_nettype none

module spi_reg_top
	import spi_reg_pkg::*;
#(
	parameter int SYNC_STAGES = 2,
	parameter int LED_WIDTH   = 4
) (
	input  logic                 clk_sample,
	input  logic                 reset,
	input  logic                 sclk,
	input  logic                 cs_n,
	input  logic                 mosi,
	output logic                 miso,
	output logic [LED_WIDTH-1:0] led
);

	// --------------------------------------------------------------------------
	// internal nets
	// --------------------------------------------------------------------------
	reg_bus_if bus0 ();

	logic      sclk_fall;
	logic      cs_active;
	logic      frame_done;
	logic      fix_sel;
	reg_data_t fix_rd_data;
	logic      ctrl_sel;
	reg_data_t ctrl_rd_data;

	// frame receiver
	spi_frame_rx #(
		.SYNC_STAGES(SYNC_STAGES)
	) frame_rx0 (
		.clk_sample (clk_sample),
		.reset      (reset),
		.sclk       (sclk),
		.cs_n       (cs_n),
		.mosi       (mosi),
		.bus        (bus0.master),
		.sclk_fall  (sclk_fall),
		.cs_active  (cs_active),
		.frame_done (frame_done)
	);

	// version identifiers
	fix_reg_list fix_list0 (
		.bus         (bus0.slave),
		.fix_sel     (fix_sel),
		.fix_rd_data (fix_rd_data)
	);

	// scratch, led and frame count
	ctrl_reg_list #(
		.LED_WIDTH(LED_WIDTH)
	) ctrl_list0 (
		.clk_sample   (clk_sample),
		.reset        (reset),
		.bus          (bus0.slave),
		.frame_done   (frame_done),
		.ctrl_sel     (ctrl_sel),
		.ctrl_rd_data (ctrl_rd_data),
		.led          (led)
	);

	// read answer back out
	spi_miso_tx miso_tx0 (
		.clk_sample   (clk_sample),
		.reset        (reset),
		.rd_en        (bus0.rd_en),
		.fix_sel      (fix_sel),
		.fix_rd_data  (fix_rd_data),
		.ctrl_sel     (ctrl_sel),
		.ctrl_rd_data (ctrl_rd_data),
		.sclk_fall    (sclk_fall),
		.cs_active    (cs_active),
		.miso         (miso)
	);

endmodule

`default_nettype wire

/* verif/spi_reg_properties.sv */
// bound into spi_frame_rx; strobe checks are held off during reset
`timescale 1ns/1ps
`default_nettype none

module spi_reg_properties (
	input wire logic clk_sample,
	input wire logic reset,
	input wire logic rd_en,
	input wire logic wr_en,
	input wire logic frame_done,
	input wire logic cs_active
);

	// --------------------------------------------------------------------------
	// strobe rules
	// --------------------------------------------------------------------------
	// read and write never together
	a_no_rd_wr: assert property (@(posedge clk_sample) disable iff (reset)
		!(rd_en && wr_en))
		else $error("rd_en and wr_en high together");

	// single cycle pulses
	a_rd_pulse: assert property (@(posedge clk_sample) disable iff (reset)
		rd_en |=> !rd_en)
		else $error("rd_en longer than one cycle");

	a_wr_pulse: assert property (@(posedge clk_sample) disable iff (reset)
		wr_en |=> !wr_en)
		else $error("wr_en longer than one cycle");

	a_done_pulse: assert property (@(posedge clk_sample) disable iff (reset)
		frame_done |=> !frame_done)
		else $error("frame_done longer than one cycle");

	// strobes only inside a frame
	a_in_frame: assert property (@(posedge clk_sample) disable iff (reset)
		(rd_en || wr_en || frame_done) |-> cs_active)
		else $error("strobe outside chip select");

endmodule

bind spi_frame_rx spi_reg_properties props0 (
	.clk_sample (clk_sample),
	.reset      (reset),
	.rd_en      (bus.rd_en),
	.wr_en      (bus.wr_en),
	.frame_done (frame_done),
	.cs_active  (cs_active)
);

`default_nettype wire

/* verif/tb_spi_reg.sv */
// assumes LED_WIDTH 4 and SYNC_STAGES 2, sclk half period of 8 clk_sample cycles; stops at first error
`timescale 1ns/1ps
`default_nettype none

module tb_spi_reg
	import spi_reg_pkg::*;
();

	localparam int LED_WIDTH   = 4;
	localparam int HALF_PERIOD = 8;
	localparam int ROW_CYCLES  = 360;

	// one frame per row
	typedef struct packed {
		spi_opcode_t          op;
		spi_addr_t            addr;
		reg_data_t            wdata;
		logic                 chk;
		reg_data_t            exp_word;
		logic [LED_WIDTH-1:0] exp_led;
		logic                 abort;
	} row_t;

	logic                 clk_sample;
	logic                 reset;
	logic                 sclk;
	logic                 cs_n;
	logic                 mosi;
	logic                 miso;
	logic [LED_WIDTH-1:0] led;

	row_t        rows[$];
	int          done_frames;
	int          timeout_limit;
	int          cycle_cnt;
	logic [31:0] lcg_state;

	spi_reg_top #(
		.SYNC_STAGES(2),
		.LED_WIDTH(LED_WIDTH)
	) dut0 (
		.clk_sample (clk_sample),
		.reset      (reset),
		.sclk       (sclk),
		.cs_n       (cs_n),
		.mosi       (mosi),
		.miso       (miso),
		.led        (led)
	);

	initial begin
		clk_sample = 1'b0;
		forever #20 clk_sample = ~clk_sample;
	end

	// --------------------------------------------------------------------------
	// helpers
	// --------------------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic check_value(input string what, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] t=%0t %s: got %h, expected %h", $time, what, actual, expected);
			$display(">>> FAIL");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	// valid, unaborted frames are the ones the counter sees
	task automatic add_row(input spi_opcode_t op, input spi_addr_t addr, input reg_data_t wdata,
			input logic chk, input reg_data_t exp_word, input logic [LED_WIDTH-1:0] exp_led,
			input logic abort);
		rows.push_back({op, addr, wdata, chk, exp_word, exp_led, abort});
		if ((op == OP_READ || op == OP_WRITE) && !abort) begin
			done_frames++;
		end
	endtask

	// mode 0 master, collects miso over the data field
	task automatic run_frame(input logic [39:0] frame, input int n_bits,
			output reg_data_t rx_word);
		int i;
		rx_word = '0;
		@(posedge clk_sample);
		cs_n <= 1'b0;
		sclk <= 1'b0;
		mosi <= frame[39];
		for (i = 0; i < n_bits; i++) begin
			// low half, mosi settles
			repeat (HALF_PERIOD - 1) @(posedge clk_sample);
			@(negedge clk_sample);
			if (i >= 24) begin
				rx_word = {rx_word[14:0], miso};
			end
			@(posedge clk_sample);
			sclk <= 1'b1;
			repeat (HALF_PERIOD) @(posedge clk_sample);
			sclk <= 1'b0;
			if (i < 39) begin
				mosi <= frame[38-i];
			end else begin
				mosi <= 1'b0;
			end
		end
		repeat (HALF_PERIOD) @(posedge clk_sample);
		cs_n <= 1'b1;
		mosi <= 1'b0;
		// idle gap between frames
		repeat (2 * HALF_PERIOD) @(posedge clk_sample);
	endtask

	// --------------------------------------------------------------------------
	// timeout
	// --------------------------------------------------------------------------
	initial begin
		cycle_cnt = 0;
		forever begin
			@(posedge clk_sample);
			cycle_cnt++;
			if (timeout_limit > 0 && cycle_cnt > timeout_limit) begin
				$display("timeout: run did not finish within %0d cycles", timeout_limit);
				$display(">>> FAIL");
				$fatal(1, "timeout");
			end
		end
	end

	// --------------------------------------------------------------------------
	// table and main sequence
	// --------------------------------------------------------------------------
	initial begin
		reg_data_t scr1;
		reg_data_t scr2;
		reg_data_t rx_word;
		int        n_bits;
		int        r;
		timeout_limit = 0;
		done_frames   = 0;
		reset = 1'b1;
		sclk  = 1'b0;
		cs_n  = 1'b1;
		mosi  = 1'b0;
		lcg_state = lcg_next(32'h054278e7);
		scr1      = lcg_state[31:16];
		lcg_state = lcg_next(lcg_state);
		scr2      = lcg_state[31:16];
		if (scr2 == scr1) begin
			scr2 = ~scr1;
		end

		// version ids, then aliases above the 9 decoded bits
		add_row(OP_READ, 16'h0000, 16'h0000, 1'b1, 16'h4448, 4'h0, 1'b0);
		add_row(OP_READ, 16'h0001, 16'h0000, 1'b1, 16'h0000, 4'h0, 1'b0);
		add_row(OP_READ, 16'h0002, 16'h0000, 1'b1, 16'h0102, 4'h0, 1'b0);
		add_row(OP_READ, 16'h0003, 16'h0000, 1'b1, 16'h0123, 4'h0, 1'b0);
		add_row(OP_READ, 16'h0004, 16'h0000, 1'b1, 16'h1001, 4'h0, 1'b0);
		add_row(OP_READ, 16'h0200, 16'h0000, 1'b1, 16'h4448, 4'h0, 1'b0);
		add_row(OP_READ, 16'h0201, 16'h0000, 1'b1, 16'h0000, 4'h0, 1'b0);
		// scratch round trip
		add_row(OP_WRITE, ADDR_SCRATCH, scr1, 1'b0, 16'h0000, 4'h0, 1'b0);
		add_row(OP_READ, ADDR_SCRATCH, 16'h0000, 1'b1, scr1, 4'h0, 1'b0);
		// counter is read only
		add_row(OP_WRITE, ADDR_FRAME_COUNT, 16'hffff, 1'b0, 16'h0000, 4'h0, 1'b0);
		add_row(OP_READ, ADDR_FRAME_COUNT, 16'h0000, 1'b1, 16'(done_frames), 4'h0, 1'b0);
		// led keeps the low bits
		add_row(OP_WRITE, ADDR_LED_CTRL, 16'h00a5, 1'b0, 16'h0000, 4'h5, 1'b0);
		add_row(OP_READ, ADDR_LED_CTRL, 16'h0000, 1'b1, 16'h0005, 4'h5, 1'b0);
		// unmapped reads
		add_row(OP_READ, 16'h0005, 16'h0000, 1'b1, 16'h0000, 4'h5, 1'b0);
		add_row(OP_READ, 16'h0013, 16'h0000, 1'b1, 16'h0000, 4'h5, 1'b0);
		// unknown opcodes, nothing moves and miso stays low
		add_row(8'h7f, ADDR_SCRATCH, 16'hbeef, 1'b1, 16'h0000, 4'h5, 1'b0);
		add_row(8'h03, ADDR_LED_CTRL, 16'h000f, 1'b1, 16'h0000, 4'h5, 1'b0);
		add_row(OP_READ, ADDR_SCRATCH, 16'h0000, 1'b1, scr1, 4'h5, 1'b0);
		// aborted at bit 30
		add_row(OP_WRITE, ADDR_SCRATCH, scr2, 1'b0, 16'h0000, 4'h5, 1'b1);
		add_row(OP_READ, ADDR_SCRATCH, 16'h0000, 1'b1, scr1, 4'h5, 1'b0);
		add_row(OP_READ, ADDR_FRAME_COUNT, 16'h0000, 1'b1, 16'(done_frames), 4'h5, 1'b0);

		timeout_limit = 2 * rows.size() * ROW_CYCLES;
		repeat (4) @(posedge clk_sample);
		reset <= 1'b0;
		repeat (4) @(posedge clk_sample);

		for (r = 0; r < rows.size(); r++) begin
			n_bits = rows[r].abort ? 30 : 40;
			run_frame({rows[r].op, rows[r].addr, rows[r].wdata}, n_bits, rx_word);
			if (rows[r].chk) begin
				check_value($sformatf("row %0d read word", r), 32'(rx_word),
					32'(rows[r].exp_word));
			end
			check_value($sformatf("row %0d led", r), 32'(led), 32'(rows[r].exp_led));
		end

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
